// File: build.f
common/xosera_pkg.sv
logic/intr_ctrl.sv
logic/vram_arb.sv
logic/xrmem_arb.sv
logic/reg_interface.sv
video/video_timing.sv
video/video_gen.sv
logic/xosera_main.sv
test/xosera_tb.sv

// File: test/xosera_tb.sv
module xosera_tb import xosera_pkg::*; ();

localparam int    H_VIS      = 16;      // small screen for simulation
localparam int    H_FP       = 2;
localparam int    H_SY       = 3;
localparam int    H_BP       = 3;
localparam int    V_VIS      = 4;
localparam int    V_FP       = 1;
localparam int    V_SY       = 1;
localparam int    V_BP       = 2;
localparam int    VRAM_AW    = 13;
localparam int    H_TOTAL    = H_VIS + H_FP + H_SY + H_BP;
localparam int    V_TOTAL    = V_VIS + V_FP + V_SY + V_BP;
localparam int    FRAME_CYCLES = H_TOTAL * V_TOTAL;
localparam addr_t DISP_BASE  = 16'h0100;        // frame buffer, below random traffic
localparam int    LINE_WORDS = H_VIS / 2;       // two pixels per word
localparam int    BUS_OPS    = 2500;            // upper bound on bus accesses in all phases
localparam int    WATCHDOG_CYCLES = 6 * 4 * FRAME_CYCLES + BUS_OPS * 4 * 2;

logic       clk;
logic       reset;
logic       bus_cs_n, bus_rd_nwr, bus_bytesel;
logic [3:0] bus_reg_num;
logic [7:0] bus_din, bus_dout;
logic       bus_intr;
logic [3:0] red, green, blue;
logic       hsync, vsync, dv_de;

integer     seed = 45018;
word_t      vram_model [2**VRAM_AW];            // shadow of VRAM contents
word_t      color_model [256];                  // shadow of colour memory
addr_t      disp_base;
word_t      line_words;
logic       arm_video = 1'b0;                   // start checking at next vsync
logic       checking = 1'b0;
logic       vsync_q = 1'b0, de_q = 1'b0;
int         px = 0, py = 0;                     // pixel position on screen
int         hx = 0, vy = 0;                     // raster position at the outputs
logic       line_de = 1'b0;                     // current line had visible pixels
int         frames_checked = 0;
int         cycle_count = 0, intr_count = 0;
int         last_pulse = 0, pulse_gap = 0;

xosera_main #(
    .H_VISIBLE(H_VIS), .H_FRONT(H_FP), .H_SYNC(H_SY), .H_BACK(H_BP),
    .V_VISIBLE(V_VIS), .V_FRONT(V_FP), .V_SYNC(V_SY), .V_BACK(V_BP),
    .VRAM_ADDR_W(VRAM_AW)
) xosera_main_inst(
    .bus_cs_n_i(bus_cs_n),
    .bus_rd_nwr_i(bus_rd_nwr),
    .bus_reg_num_i(bus_reg_num),
    .bus_bytesel_i(bus_bytesel),
    .bus_data_i(bus_din),
    .bus_data_o(bus_dout),
    .bus_intr_o(bus_intr),
    .red_o(red),
    .green_o(green),
    .blue_o(blue),
    .hsync_o(hsync),
    .vsync_o(vsync),
    .dv_de_o(dv_de),
    .reset_i(reset),
    .clk(clk)
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    if (got !== expected) begin
        $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, expected);
        $display("RESULT: FAIL");
        $fatal(1, "mismatch on %s", name);
    end
endtask

// expected colour: word at base + y*len + x/2, high byte on even x
function automatic logic [11:0] pixel_rgb(input int x, input int y);
    int     waddr;
    word_t  pix;
    color_t idx;
    waddr = (disp_base + y * line_words + x / 2) % (2**VRAM_AW);
    pix   = vram_model[waddr];
    idx   = (x % 2 == 0) ? pix[15:8] : pix[7:0];
    return color_model[idx][11:0];
endfunction

// cs low two cycles, high two; access is the first low sample
task automatic bus_write(input logic [3:0] reg_num, input logic bsel, input logic [7:0] din);
    bus_cs_n    <= 1'b0;
    bus_rd_nwr  <= 1'b0;
    bus_reg_num <= reg_num;
    bus_bytesel <= bsel;
    bus_din     <= din;
    repeat (2) @(posedge clk);
    bus_cs_n    <= 1'b1;
    repeat (2) @(posedge clk);
endtask

task automatic bus_read(input logic [3:0] reg_num, input logic bsel, output logic [7:0] dout);
    bus_cs_n    <= 1'b0;
    bus_rd_nwr  <= 1'b1;
    bus_reg_num <= reg_num;
    bus_bytesel <= bsel;
    @(posedge clk);                     // access cycle
    @(negedge clk);
    dout = bus_dout;                    // valid one cycle after access
    @(posedge clk);
    bus_cs_n    <= 1'b1;
    repeat (2) @(posedge clk);
endtask

task automatic wait_idle();
    logic [7:0] status;
    status = 8'h80;
    while (status[7]) begin
        bus_read(XM_SYS_STATUS, 1'b0, status);  // bit 7 busy
    end
endtask

task automatic reg_write16(input logic [3:0] reg_num, input word_t value);
    bus_write(reg_num, 1'b0, value[15:8]);      // latched high byte
    bus_write(reg_num, 1'b1, value[7:0]);       // completes the word
    if (reg_num == XM_XR_ADDR || reg_num == XM_XR_DATA ||
        reg_num == XM_RD_ADDR || reg_num == XM_DATA) begin
        wait_idle();
    end
endtask

task automatic reg_read16(input logic [3:0] reg_num, output word_t value);
    logic [7:0] hi, lo;
    bus_read(reg_num, 1'b0, hi);
    bus_read(reg_num, 1'b1, lo);
    value = {hi, lo};
    if (reg_num == XM_DATA || reg_num == XM_XR_DATA) begin
        wait_idle();                            // next read-ahead in flight
    end
endtask

// random bursts outside the frame buffer, then read all back
task automatic vram_traffic(input int bursts);
    addr_t start_a [16];
    int    len_a [16];
    addr_t a;
    word_t w;
    for (int b = 0; b < bursts; b++) begin
        start_a[b] = 16'h0200 + 16'($random(seed) & 32'h0FFF);
        len_a[b]   = 1 + ($random(seed) & 3);
        reg_write16(XM_WR_ADDR, start_a[b]);
        for (int i = 0; i < len_a[b]; i++) begin
            a = start_a[b] + addr_t'(i);
            w = 16'($random(seed));
            vram_model[a[VRAM_AW-1:0]] = w;
            reg_write16(XM_DATA, w);            // auto increment
        end
    end
    for (int b = 0; b < bursts; b++) begin
        reg_write16(XM_RD_ADDR, start_a[b]);
        for (int i = 0; i < len_a[b]; i++) begin
            a = start_a[b] + addr_t'(i);
            reg_read16(XM_DATA, w);
            check_value("vram read data", w, vram_model[a[VRAM_AW-1:0]]);
        end
    end
endtask

task automatic wait_frames(input int n);
    int target;
    target = frames_checked + n;
    while (frames_checked < target) @(posedge clk);
endtask

// video compare at negedge, position from dv_de and vsync
always @(negedge clk) begin
    if (!reset) begin
        // raster position from dv_de alone
        if (dv_de && !de_q) begin
            hx = 0;
        end else begin
            hx = (hx + 1) % H_TOTAL;
        end
        if (hx == 0) begin
            vy      = (dv_de && !line_de) ? 0 : (vy + 1) % V_TOTAL;  // top line after blank
            line_de = 1'b0;
        end
        line_de = line_de || dv_de;
        if (checking) begin
            check_value("hsync", hsync, hx >= H_VIS + H_FP && hx < H_VIS + H_FP + H_SY);
            check_value("vsync", vsync, vy >= V_VIS + V_FP && vy < V_VIS + V_FP + V_SY);
        end
        if (vsync && !vsync_q) begin
            if (checking) begin
                frames_checked = frames_checked + 1;
            end
            checking = checking || arm_video;
            px = 0;
            py = 0;
        end
        if (dv_de) begin
            if (checking) begin
                check_value("rgb", {red, green, blue}, pixel_rgb(px, py));
            end
            px = px + 1;
        end else begin
            check_value("rgb during blank", {red, green, blue}, 32'h0);
            if (de_q) begin                     // end of a visible line
                py = py + 1;
                px = 0;
            end
        end
        vsync_q = vsync;
        de_q    = dv_de;
    end
end

always @(negedge clk) begin
    cycle_count = cycle_count + 1;
    if (bus_intr) begin
        intr_count = intr_count + 1;
        pulse_gap  = cycle_count - last_pulse;
        last_pulse = cycle_count;
    end
end

initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
end

initial begin
    word_t      w;
    logic [7:0] b;
    int         n0;
    bus_cs_n    = 1'b1;
    bus_rd_nwr  = 1'b1;
    bus_reg_num = 4'h0;
    bus_bytesel = 1'b0;
    bus_din     = 8'h00;
    reset       = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(posedge clk);

    vram_traffic(6);                            // VRAM write and read-back

    reg_write16(XM_XR_ADDR, XR_COLOR_BASE);     // fill whole colour memory
    for (int i = 0; i < 256; i++) begin
        w = 16'($random(seed));
        color_model[i] = w;
        reg_write16(XM_XR_DATA, w);
    end
    reg_write16(XM_XR_ADDR, XR_COLOR_BASE);
    for (int i = 0; i < 256; i++) begin
        reg_read16(XM_XR_DATA, w);
        check_value("colour memory", w, color_model[i]);
    end
    reg_write16(XM_XR_ADDR, addr_t'(XR_LINE_LEN));
    reg_write16(XM_XR_DATA, LINE_WORDS);
    reg_write16(XM_XR_ADDR, addr_t'(XR_LINE_LEN));
    reg_read16(XM_XR_DATA, w);
    check_value("XR_LINE_LEN", w, LINE_WORDS);

    reg_write16(XM_WR_ADDR, DISP_BASE);         // frame buffer contents
    for (int i = 0; i < LINE_WORDS * V_VIS; i++) begin
        w = 16'($random(seed));
        vram_model[DISP_BASE + i] = w;
        reg_write16(XM_DATA, w);
    end
    reg_write16(XM_XR_ADDR, addr_t'(XR_DISP_ADDR));
    reg_write16(XM_XR_DATA, DISP_BASE);
    reg_write16(XM_XR_DATA, LINE_WORDS);        // next register is line length
    reg_write16(XM_XR_ADDR, addr_t'(XR_DISP_ADDR));
    reg_read16(XM_XR_DATA, w);
    check_value("XR_DISP_ADDR", w, DISP_BASE);
    reg_read16(XM_XR_DATA, w);
    check_value("XR_LINE_LEN", w, LINE_WORDS);
    disp_base  = DISP_BASE;
    line_words = LINE_WORDS;
    arm_video  = 1'b1;
    wait_frames(2);

    // vblank interrupt, mask bit 0, clear all pending
    reg_write16(XM_INT_CTRL, 16'h010F);
    n0 = intr_count;
    for (int f = 0; f < 2; f++) begin
        while (intr_count == n0 + f) @(posedge clk);
        bus_read(XM_INT_CTRL, 1'b1, b);
        check_value("intr status after vblank", b, 8'h01);
        reg_write16(XM_INT_CTRL, 16'h0101);
        bus_read(XM_INT_CTRL, 1'b1, b);
        check_value("intr status after clear", b, 8'h00);
    end
    check_value("bus_intr_o count", intr_count, n0 + 2);
    check_value("cycles between vblank interrupts", pulse_gap, FRAME_CYCLES);

    // software interrupts, only bit 1 enabled
    reg_write16(XM_INT_CTRL, 16'h020F);
    n0 = intr_count;
    reg_write16(XM_XR_ADDR, addr_t'(XR_VID_INTR));
    reg_write16(XM_XR_DATA, 16'h0004);          // masked bit
    repeat (4) @(posedge clk);
    check_value("bus_intr_o count masked", intr_count, n0);
    bus_read(XM_INT_CTRL, 1'b1, b);
    check_value("intr status masked", b & 8'h0E, 8'h04);
    reg_write16(XM_XR_ADDR, addr_t'(XR_VID_INTR));
    reg_write16(XM_XR_DATA, 16'h0002);          // enabled bit
    repeat (4) @(posedge clk);
    check_value("bus_intr_o count unmasked", intr_count, n0 + 1);
    reg_write16(XM_XR_ADDR, addr_t'(XR_VID_INTR));
    reg_write16(XM_XR_DATA, 16'h0002);          // still pending, no new strobe
    repeat (4) @(posedge clk);
    check_value("bus_intr_o count repeat", intr_count, n0 + 1);
    bus_read(XM_INT_CTRL, 1'b1, b);
    check_value("intr status software", b & 8'h0E, 8'h06);
    reg_write16(XM_INT_CTRL, 16'h000F);

    vram_traffic(6);                            // host traffic while display runs
    wait_frames(2);

    $display("RESULT: PASS");
    $finish;
end

endmodule

// File: logic/xosera_main.sv
`default_nettype none

module xosera_main import xosera_pkg::*; #(
    parameter int H_VISIBLE   = 640,
    parameter int H_FRONT     = 16,
    parameter int H_SYNC      = 96,
    parameter int H_BACK      = 48,
    parameter int V_VISIBLE   = 480,
    parameter int V_FRONT     = 10,
    parameter int V_SYNC      = 2,
    parameter int V_BACK      = 33,
    parameter int VRAM_ADDR_W = 15
) (
    input  wire logic       bus_cs_n_i,     // register select, active low
    input  wire logic       bus_rd_nwr_i,   // 0 = write, 1 = read
    input  wire logic [3:0] bus_reg_num_i,
    input  wire logic       bus_bytesel_i,  // 0 = even byte
    input  wire logic [7:0] bus_data_i,
    output logic      [7:0] bus_data_o,
    output logic            bus_intr_o,
    output logic      [3:0] red_o,
    output logic      [3:0] green_o,
    output logic      [3:0] blue_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o,
    input  wire logic       reset_i,
    input  wire logic       clk
);

logic       vram_sel, vram_ack;     // host VRAM port
mem_req_t   vram_req;
word_t      vram_data;              // shared VRAM read data
logic       xr_sel, xr_ack;         // host XR port
mem_req_t   xr_req;
word_t      xr_data;
logic       vreg_wr;                // video register bus
xr_reg_e    vreg_num;
word_t      vreg_data, vreg_rdata;
logic       vgen_sel;               // video fetch
addr_t      vgen_addr;
color_t     color_index;
rgb_t       rgb;
vid_sync_t  vid_sync;               // aligned with rgb
vid_sync_t  vid_status;             // raw timing for status reads
intr_t      intr_trigger, intr_mask, intr_clear, intr_status;

reg_interface reg_interface(
    .bus_cs_n_i(bus_cs_n_i),
    .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i),
    .bus_data_o(bus_data_o),
    .vram_sel_o(vram_sel),
    .vram_ack_i(vram_ack),
    .vram_req_o(vram_req),
    .vram_data_i(vram_data),
    .xr_sel_o(xr_sel),
    .xr_ack_i(xr_ack),
    .xr_req_o(xr_req),
    .xr_data_i(xr_data),
    .vid_status_i(vid_status),
    .intr_status_i(intr_status),
    .intr_mask_o(intr_mask),
    .intr_clear_o(intr_clear),
    .reset_i(reset_i),
    .clk(clk)
);

vram_arb #(.VRAM_ADDR_W(VRAM_ADDR_W)) vram_arb(
    .vgen_sel_i(vgen_sel),
    .vgen_addr_i(vgen_addr),
    .regs_sel_i(vram_sel),
    .regs_req_i(vram_req),
    .regs_ack_o(vram_ack),
    .vram_data_o(vram_data),
    .clk(clk)
);

xrmem_arb xrmem_arb(
    .xr_sel_i(xr_sel),
    .xr_req_i(xr_req),
    .xr_ack_o(xr_ack),
    .xr_data_o(xr_data),
    .vreg_wr_o(vreg_wr),
    .vreg_num_o(vreg_num),
    .vreg_data_o(vreg_data),
    .vreg_rdata_i(vreg_rdata),
    .color_index_i(color_index),
    .rgb_o(rgb),
    .reset_i(reset_i),
    .clk(clk)
);

intr_ctrl intr_ctrl(
    .intr_trigger_i(intr_trigger),
    .intr_mask_i(intr_mask),
    .intr_clear_i(intr_clear),
    .intr_status_o(intr_status),
    .bus_intr_o(bus_intr_o),
    .reset_i(reset_i),
    .clk(clk)
);

video_gen #(
    .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
) video_gen(
    .vreg_wr_i(vreg_wr),
    .vreg_num_i(vreg_num),
    .vreg_data_i(vreg_data),
    .vreg_rdata_o(vreg_rdata),
    .vgen_sel_o(vgen_sel),
    .vgen_addr_o(vgen_addr),
    .vram_data_i(vram_data),
    .color_index_o(color_index),
    .sync_o(vid_sync),
    .status_o(vid_status),
    .intr_trigger_o(intr_trigger),
    .reset_i(reset_i),
    .clk(clk)
);

assign hsync_o                    = vid_sync.hsync;
assign vsync_o                    = vid_sync.vsync;
assign dv_de_o                    = vid_sync.dv_de;
assign {red_o, green_o, blue_o}   = vid_sync.dv_de ? rgb : '0;   // black outside display

endmodule
`default_nettype wire

// File: video/video_gen.sv
`default_nettype none

module video_gen import xosera_pkg::*; #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  wire logic    vreg_wr_i,
    input  wire xr_reg_e vreg_num_i,
    input  wire word_t   vreg_data_i,
    output word_t        vreg_rdata_o,
    output logic         vgen_sel_o,        // VRAM fetch, data next cycle
    output addr_t        vgen_addr_o,
    input  wire word_t   vram_data_i,
    output color_t       color_index_o,
    output vid_sync_t    sync_o,            // lines up with rgb
    output vid_sync_t    status_o,          // straight from counters
    output intr_t        intr_trigger_o,
    input  wire logic    reset_i,
    input  wire logic    clk
);

localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

logic [15:0]     h_count, v_count;
color_t          border_color;
addr_t           disp_addr;
word_t           line_len;
addr_t           line_addr;         // first word of current line
addr_t           fetch_addr;
word_t           pix_word;          // two pixels, high byte first
logic            line_end;
vid_sync_t [2:0] sync_pipe;         // fetch, latch, lookup stages

video_timing #(
    .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
) video_timing(
    .sync_o(status_o),
    .h_count_o(h_count),
    .v_count_o(v_count),
    .reset_i(reset_i),
    .clk(clk)
);

always_ff @(posedge clk) begin
    if (reset_i) begin
        border_color <= '0;
        disp_addr    <= '0;
        line_len     <= '0;
    end else if (vreg_wr_i) begin
        case (vreg_num_i)
            XR_BORDER:    border_color <= vreg_data_i[7:0];
            XR_DISP_ADDR: disp_addr    <= vreg_data_i;
            XR_LINE_LEN:  line_len     <= vreg_data_i;
            default: ;                          // XR_VID_INTR only triggers
        endcase
    end
end

always_comb begin
    case (vreg_num_i)
        XR_BORDER:    vreg_rdata_o = {8'h00, border_color};
        XR_DISP_ADDR: vreg_rdata_o = disp_addr;
        XR_LINE_LEN:  vreg_rdata_o = line_len;
        default:      vreg_rdata_o = '0;
    endcase
end

always_comb begin
    intr_trigger_o    = '0;
    intr_trigger_o[0] = (h_count == 16'h0) && (v_count == 16'(V_VISIBLE));  // vblank start
    if (vreg_wr_i && vreg_num_i == XR_VID_INTR) begin
        intr_trigger_o[3:1] = vreg_data_i[3:1];
    end
end

// fetch on even pixels, two cycles ahead of display
assign vgen_sel_o  = status_o.dv_de && !h_count[0];
assign vgen_addr_o = fetch_addr;
assign line_end    = (h_count == 16'(H_TOTAL - 1));

always_ff @(posedge clk) begin
    if (reset_i) begin
        line_addr  <= '0;
        fetch_addr <= '0;
    end else if (line_end && v_count == 16'(V_TOTAL - 1)) begin
        line_addr  <= disp_addr;                // top of frame
        fetch_addr <= disp_addr;
    end else if (line_end && v_count < 16'(V_VISIBLE)) begin
        line_addr  <= line_addr + line_len;
        fetch_addr <= line_addr + line_len;
    end else if (vgen_sel_o) begin
        fetch_addr <= fetch_addr + 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (h_count[0]) begin
        pix_word <= vram_data_i;                // video data on the odd cycle
    end
end

assign color_index_o = h_count[0] ? pix_word[7:0] : pix_word[15:8];

always_ff @(posedge clk) begin
    if (reset_i) begin
        sync_pipe <= '0;
    end else begin
        sync_pipe <= {sync_pipe[1:0], status_o};
    end
end

assign sync_o = sync_pipe[2];

endmodule
`default_nettype wire

// File: video/video_timing.sv
`default_nettype none

module video_timing import xosera_pkg::*; #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    output vid_sync_t       sync_o,
    output logic     [15:0] h_count_o,  // pixel within line
    output logic     [15:0] v_count_o,  // line within frame
    input  wire logic       reset_i,
    input  wire logic       clk
);

localparam int H_TOTAL      = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
localparam int V_TOTAL      = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
localparam int H_SYNC_START = H_VISIBLE + H_FRONT;
localparam int V_SYNC_START = V_VISIBLE + V_FRONT;

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count_o <= '0;
        v_count_o <= '0;
    end else if (h_count_o == 16'(H_TOTAL - 1)) begin
        h_count_o <= '0;
        if (v_count_o == 16'(V_TOTAL - 1)) begin
            v_count_o <= '0;                        // new frame
        end else begin
            v_count_o <= v_count_o + 1'b1;
        end
    end else begin
        h_count_o <= h_count_o + 1'b1;
    end
end

always_comb begin
    sync_o.h_blank = h_count_o >= 16'(H_VISIBLE);
    sync_o.v_blank = v_count_o >= 16'(V_VISIBLE);
    sync_o.hsync   = (h_count_o >= 16'(H_SYNC_START))
                     && (h_count_o < 16'(H_SYNC_START + H_SYNC));
    sync_o.vsync   = (v_count_o >= 16'(V_SYNC_START))
                     && (v_count_o < 16'(V_SYNC_START + V_SYNC));
    sync_o.dv_de   = !sync_o.h_blank && !sync_o.v_blank;
end

endmodule
`default_nettype wire

// File: logic/reg_interface.sv
`default_nettype none

module reg_interface import xosera_pkg::*; (
    input  wire logic       bus_cs_n_i,     // sampled on clk
    input  wire logic       bus_rd_nwr_i,
    input  wire logic [3:0] bus_reg_num_i,
    input  wire logic       bus_bytesel_i,  // 0 = high byte
    input  wire logic [7:0] bus_data_i,
    output logic      [7:0] bus_data_o,
    output logic            vram_sel_o,     // held until ack
    input  wire logic       vram_ack_i,
    output mem_req_t        vram_req_o,
    input  wire word_t      vram_data_i,    // valid cycle after ack
    output logic            xr_sel_o,
    input  wire logic       xr_ack_i,
    output mem_req_t        xr_req_o,
    input  wire word_t      xr_data_i,      // valid with ack
    input  wire vid_sync_t  vid_status_i,
    input  wire intr_t      intr_status_i,
    output intr_t           intr_mask_o,
    output intr_t           intr_clear_o,   // one-cycle pulse
    input  wire logic       reset_i,
    input  wire logic       clk
);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_VRAM,                        // waiting for VRAM grant
    ST_VRAM_RD,                     // VRAM read data arrives
    ST_XR                           // waiting for XR ack
} state_e;

state_e     state;
logic       cs_n_q;                 // cs from previous cycle
logic       access;
reg_num_e   reg_num;
logic [7:0] byte_hi;                // even byte latch
word_t      wr_word, rd_word;
addr_t      xr_addr, rd_addr, wr_addr;
word_t      xr_rd_buf, vram_rd_buf; // read-ahead results
mem_req_t   req;                    // pending VRAM or XR request
logic       busy;

assign access     = cs_n_q && !bus_cs_n_i;      // falling edge of cs
assign reg_num    = reg_num_e'(bus_reg_num_i);
assign wr_word    = {byte_hi, bus_data_i};
assign busy       = (state != ST_IDLE);
assign vram_sel_o = (state == ST_VRAM);
assign xr_sel_o   = (state == ST_XR);
assign vram_req_o = req;
assign xr_req_o   = req;

always_comb begin
    case (reg_num)
        XM_XR_ADDR:    rd_word = xr_addr;
        XM_XR_DATA:    rd_word = xr_rd_buf;
        XM_RD_ADDR:    rd_word = rd_addr;
        XM_WR_ADDR:    rd_word = wr_addr;
        XM_DATA:       rd_word = vram_rd_buf;
        XM_INT_CTRL:   rd_word = {4'h0, intr_mask_o, 4'h0, intr_status_i};
        XM_SYS_STATUS: rd_word = {busy, vid_status_i.h_blank, vid_status_i.v_blank, 13'h0};
        default:       rd_word = '0;
    endcase
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        state        <= ST_IDLE;
        cs_n_q       <= 1'b1;
        bus_data_o   <= '0;
        xr_addr      <= '0;
        rd_addr      <= '0;
        wr_addr      <= '0;
        req          <= '0;
        intr_mask_o  <= '0;
        intr_clear_o <= '0;
    end else begin
        cs_n_q       <= bus_cs_n_i;
        intr_clear_o <= '0;

        // complete pending request
        case (state)
            ST_VRAM: begin
                if (vram_ack_i) begin
                    state <= req.wr ? ST_IDLE : ST_VRAM_RD;
                    if (req.wr) begin
                        wr_addr <= wr_addr + 1'b1;
                    end
                end
            end
            ST_VRAM_RD: begin
                vram_rd_buf <= vram_data_i;
                state       <= ST_IDLE;
            end
            ST_XR: begin
                if (xr_ack_i) begin
                    state <= ST_IDLE;
                    if (req.wr) begin
                        xr_addr <= xr_addr + 1'b1;
                    end else begin
                        xr_rd_buf <= xr_data_i;
                    end
                end
            end
            default: ;
        endcase

        if (access && bus_rd_nwr_i) begin
            bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
            if (bus_bytesel_i && reg_num == XM_DATA) begin      // next prefetch
                rd_addr <= rd_addr + 1'b1;
                req     <= '{wr: 1'b0, addr: rd_addr + 1'b1, data: '0};
                state   <= ST_VRAM;
            end
            if (bus_bytesel_i && reg_num == XM_XR_DATA) begin   // next read-ahead
                xr_addr <= xr_addr + 1'b1;
                req     <= '{wr: 1'b0, addr: xr_addr + 1'b1, data: '0};
                state   <= ST_XR;
            end
        end else if (access && !bus_bytesel_i) begin
            byte_hi <= bus_data_i;
        end else if (access) begin                          // odd byte completes word
            case (reg_num)
                XM_XR_ADDR: begin
                    xr_addr <= wr_word;
                    req     <= '{wr: 1'b0, addr: wr_word, data: '0};
                    state   <= ST_XR;
                end
                XM_XR_DATA: begin
                    req   <= '{wr: 1'b1, addr: xr_addr, data: wr_word};
                    state <= ST_XR;
                end
                XM_RD_ADDR: begin
                    rd_addr <= wr_word;
                    req     <= '{wr: 1'b0, addr: wr_word, data: '0};
                    state   <= ST_VRAM;
                end
                XM_WR_ADDR: wr_addr <= wr_word;
                XM_DATA: begin
                    req   <= '{wr: 1'b1, addr: wr_addr, data: wr_word};
                    state <= ST_VRAM;
                end
                XM_INT_CTRL: begin
                    intr_mask_o  <= byte_hi[3:0];
                    intr_clear_o <= bus_data_i[3:0];    // write 1 to clear
                end
                default: ;
            endcase
        end
    end
end

// a new request never cuts off a pending one on the other path
assert property (@(posedge clk) disable iff (reset_i)
    ($rose(vram_sel_o) |-> !$past(xr_sel_o)) and ($rose(xr_sel_o) |-> !$past(vram_sel_o)));

endmodule
`default_nettype wire

// File: logic/xrmem_arb.sv
`default_nettype none

module xrmem_arb import xosera_pkg::*; (
    input  wire logic     xr_sel_i,
    input  wire mem_req_t xr_req_i,
    output logic          xr_ack_o,     // one cycle after sel
    output word_t         xr_data_o,    // valid with ack
    output logic          vreg_wr_o,
    output xr_reg_e       vreg_num_o,
    output word_t         vreg_data_o,
    input  wire word_t    vreg_rdata_i,
    input  wire color_t   color_index_i,
    output rgb_t          rgb_o,        // cycle after index
    input  wire logic     reset_i,
    input  wire logic     clk
);

word_t color_mem [256];             // rgb in low 12 bits
logic  is_color;
logic  xr_go;                       // first cycle of a host access

assign is_color    = (xr_req_i.addr & XR_COLOR_BASE) != '0;
assign xr_go       = xr_sel_i && !xr_ack_o;
assign vreg_wr_o   = xr_go && xr_req_i.wr && !is_color;
assign vreg_num_o  = xr_reg_e'(xr_req_i.addr[1:0]);
assign vreg_data_o = xr_req_i.data;

always_ff @(posedge clk) begin
    if (reset_i) begin
        xr_ack_o <= 1'b0;
    end else begin
        xr_ack_o <= xr_go;
    end
end

always_ff @(posedge clk) begin
    if (xr_go && xr_req_i.wr && is_color) begin
        color_mem[xr_req_i.addr[7:0]] <= xr_req_i.data;
    end
    xr_data_o <= is_color ? color_mem[xr_req_i.addr[7:0]] : vreg_rdata_i;
    rgb_o     <= rgb_t'(color_mem[color_index_i][11:0]);   // video lookup port
end

endmodule
`default_nettype wire

// File: logic/vram_arb.sv
`default_nettype none

module vram_arb import xosera_pkg::*; #(
    parameter int VRAM_ADDR_W = 15
) (
    input  wire logic     vgen_sel_i,   // video fetch, always wins
    input  wire addr_t    vgen_addr_i,
    input  wire logic     regs_sel_i,   // host, held until ack
    input  wire mem_req_t regs_req_i,
    output logic          regs_ack_o,   // grant cycle
    output word_t         vram_data_o,  // cycle after select or grant
    input  wire logic     clk
);

word_t mem [2**VRAM_ADDR_W];
addr_t rd_addr;

assign regs_ack_o = regs_sel_i && !vgen_sel_i;   // host gets leftover cycles
assign rd_addr    = vgen_sel_i ? vgen_addr_i : regs_req_i.addr;

always_ff @(posedge clk) begin
    if (regs_ack_o && regs_req_i.wr) begin
        mem[regs_req_i.addr[VRAM_ADDR_W-1:0]] <= regs_req_i.data;   // whole word
    end
    vram_data_o <= mem[rd_addr[VRAM_ADDR_W-1:0]];
end

// host releases its request right after the grant
assert property (@(posedge clk) regs_ack_o |=> !regs_sel_i);

endmodule
`default_nettype wire

// File: logic/intr_ctrl.sv
`default_nettype none

module intr_ctrl import xosera_pkg::*; (
    input  wire intr_t  intr_trigger_i, // one-cycle pulses
    input  wire intr_t  intr_mask_i,
    input  wire intr_t  intr_clear_i,
    output intr_t       intr_status_o,  // sticky
    output logic        bus_intr_o,
    input  wire logic   reset_i,
    input  wire logic   clk
);

always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_intr_o    <= 1'b0;
        intr_status_o <= '0;
    end else begin
        // new, enabled and not already pending
        bus_intr_o    <= |(intr_trigger_i & intr_mask_i & ~intr_status_o);
        intr_status_o <= (intr_status_o | intr_trigger_i) & ~intr_clear_i;
    end
end

// triggers never come back to back, so the strobe is a single cycle
assert property (@(posedge clk) disable iff (reset_i) bus_intr_o |=> !bus_intr_o);

endmodule
`default_nettype wire

// File: common/xosera_pkg.sv
package xosera_pkg;

typedef logic [15:0] word_t;        // 16-bit VRAM or XR data word
typedef logic [15:0] addr_t;        // VRAM or XR word address
typedef logic [7:0]  color_t;       // colour memory index

// 12-bit colour, low 12 bits of a colour memory word
typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
} rgb_t;

// bit 0 vblank start, bits 3..1 software
typedef logic [3:0]  intr_t;

// host bus register numbers
typedef enum logic [3:0] {
    XM_XR_ADDR    = 4'h0,           // XR address, read-ahead on write
    XM_XR_DATA    = 4'h1,           // XR data, auto increment
    XM_RD_ADDR    = 4'h2,           // VRAM read address, prefetch on write
    XM_WR_ADDR    = 4'h3,           // VRAM write address
    XM_DATA       = 4'h4,           // VRAM data, auto increment
    XM_INT_CTRL   = 4'h5,           // mask high byte, status/clear low byte
    XM_SYS_STATUS = 4'h6            // busy and blank flags
} reg_num_e;

// video registers at XR addresses 0..3
typedef enum logic [1:0] {
    XR_BORDER    = 2'h0,            // reserved, read back only
    XR_DISP_ADDR = 2'h1,            // first VRAM word of the frame
    XR_LINE_LEN  = 2'h2,            // words per line
    XR_VID_INTR  = 2'h3             // software interrupt trigger
} xr_reg_e;

localparam addr_t XR_COLOR_BASE = 16'h8000;     // bit 15 selects colour memory

// host request toward VRAM or XR
typedef struct packed {
    logic  wr;                      // 1 = write
    addr_t addr;
    word_t data;
} mem_req_t;

typedef struct packed {
    logic hsync;                    // active high
    logic vsync;                    // active high
    logic h_blank;                  // right of visible area
    logic v_blank;                  // below visible area
    logic dv_de;                    // visible pixel
} vid_sync_t;

endpackage
